/* Makefile */
# Verilator build and run of the coprocessor 0 testbench

TOP = coprocessor0Tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f coprocessor0.f \
		--top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* coprocessor0.f */
+incdir+hdl
+incdir+testbench
hdl/cp0Pkg.sv
hdl/cp0Timer.sv
hdl/cp0ExcUnit.sv
hdl/cp0ReadMux.sv
hdl/coprocessor0.sv
testbench/coprocessor0Tb.sv

/* hdl/coprocessor0.sv */
//==================================================
// Coprocessor 0 top: timer, exception unit and read
// mux, plus the user mode flag for the pipeline
//==================================================
`timescale 1ns/1ps
`include "cp0_settings.svh"

module coprocessor0
    import cp0Pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`CP0_ADDR_W-1:0] regAddr_i,
    input  regWrite_t              regWr_i,
    input  excReq_t                exc_i,
    input  logic [`HW_INT_W-1:0]   intr_i,
    output logic [31:0]            rdata_o,
    output status_t                status_o,
    output cause_t                 cause_o,
    output logic [31:0]            epc_o,
    output logic                   userMode_o,
    output logic                   timerInt_o
);

    status_t     status;
    cause_t      cause;
    logic [31:0] epc;
    logic [31:0] badVAddr;
    logic [31:0] count;
    logic [31:0] compare;

    cp0Timer uTimer (
        .clk        (clk),
        .rst        (rst),
        .regWr_i    (regWr_i),
        .count_o    (count),
        .compare_o  (compare),
        .timerInt_o (timerInt_o)
    );

    cp0ExcUnit uExcUnit (
        .clk        (clk),
        .rst        (rst),
        .exc_i      (exc_i),
        .regWr_i    (regWr_i),
        .intr_i     (intr_i),
        .status_o   (status),
        .cause_o    (cause),
        .epc_o      (epc),
        .badVAddr_o (badVAddr)
    );

    cp0ReadMux uReadMux (
        .regAddr_i  (regAddr_i),
        .status_i   (status),
        .cause_i    (cause),
        .epc_i      (epc),
        .badVAddr_i (badVAddr),
        .count_i    (count),
        .compare_i  (compare),
        .rdata_o    (rdata_o)
    );

    // Kernel mode whenever an exception or error level is active
    assign userMode_o = status.um & ~(status.erl | status.exl);

    assign status_o = status;
    assign cause_o  = cause;
    assign epc_o    = epc;

endmodule

/* hdl/cp0ExcUnit.sv */
//==================================================
// CP0 exception unit: Status, Cause, EPC, BadVAddr
// updated by exceptions, ERET, IRQs and writes
//==================================================
`timescale 1ns/1ps
`include "cp0_settings.svh"

module cp0ExcUnit
    import cp0Pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  excReq_t              exc_i,
    input  regWrite_t            regWr_i,
    input  logic [`HW_INT_W-1:0] intr_i,
    output status_t              status_o,
    output cause_t               cause_o,
    output logic [31:0]          epc_o,
    output logic [31:0]          badVAddr_o
);

    status_t     statusQ;
    cause_t      causeQ;
    logic [31:0] epcQ;
    logic [31:0] badVAddrQ;
    status_t     wrStatus;
    cause_t      wrCause;
    logic        isEntry;
    logic [4:0]  excCode;
    logic [31:0] epcNext;
    logic        isAddrErr;

    // Field views of the software write word
    assign wrStatus = regWr_i.data;
    assign wrCause  = regWr_i.data;

    // Branch delay slot faults restart at the branch
    assign epcNext   = exc_i.inSlot ? exc_i.pc - 32'd4 : exc_i.pc;
    assign isAddrErr = (exc_i.kind == excAdEL) || (exc_i.kind == excAdES);

    always_comb begin
        isEntry = 1'b1;
        excCode = `EXC_CODE_INT;
        case (exc_i.kind)
            excIntr:    excCode = `EXC_CODE_INT;
            excCpU:     excCode = `EXC_CODE_CPU;
            excRI:      excCode = `EXC_CODE_RI;
            excOv:      excCode = `EXC_CODE_OV;
            excTrap:    excCode = `EXC_CODE_TR;
            excSysCall: excCode = `EXC_CODE_SYS;
            excBp:      excCode = `EXC_CODE_BP;
            excAdEL:    excCode = `EXC_CODE_ADEL;
            excAdES:    excCode = `EXC_CODE_ADES;
            default:    isEntry = 1'b0;     // None and ERET
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            statusQ   <= `CP0_STATUS_RST;
            causeQ    <= '0;
            epcQ      <= 32'd0;
            badVAddrQ <= 32'd0;
        end else begin
            causeQ.ip[7:2] <= intr_i;   // Hardware lines sampled one cycle late

            if (exc_i.valid) begin
                if (isEntry) begin
                    // Nested fault keeps the first EPC
                    if (!statusQ.exl) begin
                        epcQ      <= epcNext;
                        causeQ.bd <= exc_i.inSlot;
                    end
                    statusQ.exl    <= 1'b1;
                    causeQ.excCode <= excCode;
                    if (isAddrErr) begin
                        badVAddrQ <= exc_i.badAddr;
                    end
                    if (exc_i.kind == excCpU) begin
                        causeQ.ce <= exc_i.cpNum;
                    end
                end else if (exc_i.kind == excEret) begin
                    statusQ.exl <= 1'b0;
                end
            end else if (regWr_i.en) begin
                case (regWr_i.addr)
                    `CP0_REG_STATUS: begin
                        statusQ.cu0 <= wrStatus.cu0;
                        statusQ.bev <= wrStatus.bev;
                        statusQ.im  <= wrStatus.im;
                        statusQ.um  <= wrStatus.um;
                        statusQ.erl <= wrStatus.erl;
                        statusQ.exl <= wrStatus.exl;
                        statusQ.ie  <= wrStatus.ie;
                    end
                    `CP0_REG_CAUSE: begin
                        causeQ.iv      <= wrCause.iv;
                        causeQ.ip[1:0] <= wrCause.ip[1:0];  // Software IRQs
                    end
                    `CP0_REG_EPC:      epcQ      <= regWr_i.data;
                    `CP0_REG_BADVADDR: badVAddrQ <= regWr_i.data;
                    default: ;
                endcase
            end
        end
    end

    assign status_o   = statusQ;
    assign cause_o    = causeQ;
    assign epc_o      = epcQ;
    assign badVAddr_o = badVAddrQ;

endmodule

/* hdl/cp0Pkg.sv */
//==================================================
// CP0 types: exception kinds, request structs and
// Status / Cause register layouts
//==================================================
package cp0Pkg;

`include "cp0_settings.svh"

    typedef enum logic [3:0] {
        excNone    = 4'd0,
        excIntr    = 4'd1,
        excCpU     = 4'd2,
        excRI      = 4'd3,
        excOv      = 4'd4,
        excTrap    = 4'd5,
        excSysCall = 4'd6,
        excBp      = 4'd7,
        excAdEL    = 4'd8,
        excAdES    = 4'd9,
        excEret    = 4'd10
    } excType_t;

    // Exception or ERET request from the pipeline
    typedef struct packed {
        logic        valid;
        excType_t    kind;
        logic [31:0] pc;
        logic [31:0] badAddr;   // Faulting address for AdEL/AdES
        logic [1:0]  cpNum;     // Unusable coprocessor for CpU
        logic        inSlot;    // Instruction sits in a delay slot
    } excReq_t;

    typedef struct packed {
        logic                   en;
        logic [`CP0_ADDR_W-1:0] addr;
        logic [31:0]            data;
    } regWrite_t;

    typedef struct packed {
        logic [2:0] zero31;
        logic       cu0;        // 28
        logic [4:0] zero27;
        logic       bev;        // 22
        logic [5:0] zero21;
        logic [7:0] im;         // 15:8
        logic [2:0] zero7;
        logic       um;         // 4
        logic       zero3;
        logic       erl;
        logic       exl;
        logic       ie;
    } status_t;

    typedef struct packed {
        logic       bd;         // 31
        logic       zero30;
        logic [1:0] ce;         // 29:28
        logic [3:0] zero27;
        logic       iv;         // 23
        logic [6:0] zero22;
        logic [7:0] ip;         // 15:8 with only 9:8 writable
        logic       zero7;
        logic [4:0] excCode;    // 6:2
        logic [1:0] zero1;
    } cause_t;

endpackage

/* hdl/cp0ReadMux.sv */
//==================================================
// CP0 read mux: picks the register word for the
// software read port where unknown numbers read zero
//==================================================
`timescale 1ns/1ps
`include "cp0_settings.svh"

module cp0ReadMux
    import cp0Pkg::*;
(
    input  logic [`CP0_ADDR_W-1:0] regAddr_i,
    input  status_t                status_i,
    input  cause_t                 cause_i,
    input  logic [31:0]            epc_i,
    input  logic [31:0]            badVAddr_i,
    input  logic [31:0]            count_i,
    input  logic [31:0]            compare_i,
    output logic [31:0]            rdata_o
);

    always_comb begin
        case (regAddr_i)
            `CP0_REG_BADVADDR: rdata_o = badVAddr_i;
            `CP0_REG_COUNT:    rdata_o = count_i;
            `CP0_REG_COMPARE:  rdata_o = compare_i;
            `CP0_REG_STATUS:   rdata_o = status_i;
            `CP0_REG_CAUSE:    rdata_o = cause_i;
            `CP0_REG_EPC:      rdata_o = epc_i;
            `CP0_REG_PRID:     rdata_o = `CP0_PRID_VALUE;
            `CP0_REG_CONFIG:   rdata_o = `CP0_CONFIG_VALUE;   // K0 fixed
            default:           rdata_o = 32'd0;
        endcase
    end

endmodule

/* hdl/cp0Timer.sv */
//==================================================
// CP0 timer: Count, Compare and the sticky timer
// interrupt raised on a Count/Compare match
//==================================================
`timescale 1ns/1ps
`include "cp0_settings.svh"

module cp0Timer
    import cp0Pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  regWrite_t   regWr_i,
    output logic [31:0] count_o,
    output logic [31:0] compare_o,
    output logic        timerInt_o
);

    logic [31:0] countQ;
    logic [31:0] compareQ;
    logic        timerIntQ;
    logic        countWr;
    logic        compareWr;
    logic        match;

    assign countWr   = regWr_i.en && (regWr_i.addr == `CP0_REG_COUNT);
    assign compareWr = regWr_i.en && (regWr_i.addr == `CP0_REG_COMPARE);

    // Compare of zero disables the timer
    assign match = (countQ == compareQ) && (compareQ != 32'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            countQ    <= 32'd0;
            compareQ  <= 32'd0;
            timerIntQ <= 1'b0;
        end else begin
            countQ <= countWr ? regWr_i.data : countQ + 32'd1;

            if (compareWr) begin
                compareQ  <= regWr_i.data;
                timerIntQ <= 1'b0;     // Ack by rewriting Compare
            end else if (match) begin
                timerIntQ <= 1'b1;
            end
        end
    end

    assign count_o    = countQ;
    assign compare_o  = compareQ;
    assign timerInt_o = timerIntQ;

endmodule

/* hdl/cp0_settings.svh */
//==================================================
// CP0 settings: register numbers, exception codes,
// read-only constants and reset values
//==================================================
`ifndef CP0_SETTINGS_SVH
`define CP0_SETTINGS_SVH

`define CP0_ADDR_W          5
`define HW_INT_W            6

// Register numbers
`define CP0_REG_BADVADDR    5'd8
`define CP0_REG_COUNT       5'd9
`define CP0_REG_COMPARE     5'd11
`define CP0_REG_STATUS      5'd12
`define CP0_REG_CAUSE       5'd13
`define CP0_REG_EPC         5'd14
`define CP0_REG_PRID        5'd15
`define CP0_REG_CONFIG      5'd16

// Cause.ExcCode values
`define EXC_CODE_INT        5'd0
`define EXC_CODE_ADEL       5'd4
`define EXC_CODE_ADES       5'd5
`define EXC_CODE_SYS        5'd8
`define EXC_CODE_BP         5'd9
`define EXC_CODE_RI         5'd10
`define EXC_CODE_CPU        5'd11
`define EXC_CODE_OV         5'd12
`define EXC_CODE_TR         5'd13

`define CP0_PRID_VALUE      32'h0001_8000
`define CP0_CONFIG_VALUE    32'h8000_0082   // M set and K0 uncached
`define CP0_STATUS_RST      32'h0040_0004   // BEV and ERL

`endif

/* testbench/cp0TbTasks.svh */
//==================================================
// Coprocessor 0 testbench tasks: bus drivers, value
// check and the directed tests
//==================================================

task automatic checkValue(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (actual !== expected) begin
        errors++;
        $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
endtask

task automatic startWrite(input logic [4:0] addr, input logic [31:0] data);
    regWr.en   <= 1'b1;
    regWr.addr <= addr;
    regWr.data <= data;
endtask

task automatic startExc(input excType_t kind, input logic [31:0] pc,
                        input logic [31:0] badAddr, input logic [1:0] cpNum,
                        input logic inSlot);
    exc.valid   <= 1'b1;
    exc.kind    <= kind;
    exc.pc      <= pc;
    exc.badAddr <= badAddr;
    exc.cpNum   <= cpNum;
    exc.inSlot  <= inSlot;
endtask

// Request is taken on this edge and strobes drop after it
task automatic finishCycle();
    @(posedge clk);
    regWr.en  <= 1'b0;
    exc.valid <= 1'b0;
endtask

task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
    @(posedge clk);
    startWrite(addr, data);
    finishCycle();
endtask

task automatic sendExc(input excType_t kind, input logic [31:0] pc,
                       input logic [31:0] badAddr, input logic [1:0] cpNum,
                       input logic inSlot);
    @(posedge clk);
    startExc(kind, pc, badAddr, cpNum, inSlot);
    finishCycle();
endtask

task automatic eret();
    sendExc(excEret, 32'd0, 32'd0, 2'd0, 1'b0);
endtask

task automatic checkReg(input string name, input logic [4:0] addr,
                        input logic [31:0] expected);
    @(posedge clk);
    regAddr <= addr;
    @(negedge clk);     // Read path is combinational
    checkValue(name, expected, rdata);
endtask

// ExcCode table of the MIPS32 Cause register
function automatic logic [4:0] expectedCode(input excType_t kind);
    case (kind)
        excAdEL:    return 5'd4;
        excAdES:    return 5'd5;
        excSysCall: return 5'd8;
        excBp:      return 5'd9;
        excRI:      return 5'd10;
        excCpU:     return 5'd11;
        excOv:      return 5'd12;
        excTrap:    return 5'd13;
        default:    return 5'd0;
    endcase
endfunction

task automatic resetTest();
    @(negedge clk);
    checkValue("rdata_o (Count)", 32'd0, rdata);
    checkReg("rdata_o (Status)", `CP0_REG_STATUS, 32'h0040_0004);
    checkReg("rdata_o (Cause)", `CP0_REG_CAUSE, 32'd0);
    checkReg("rdata_o (EPC)", `CP0_REG_EPC, 32'd0);
    checkReg("rdata_o (BadVAddr)", `CP0_REG_BADVADDR, 32'd0);
    checkReg("rdata_o (Compare)", `CP0_REG_COMPARE, 32'd0);
    checkReg("rdata_o (PrId)", `CP0_REG_PRID, 32'h0001_8000);
    checkReg("rdata_o (Config)", `CP0_REG_CONFIG, 32'h8000_0082);
    checkReg("rdata_o (register 3)", 5'd3, 32'd0);
    checkValue("timerInt_o", 32'd0, 32'(timerInt));
endtask

task automatic writeTest();
    logic [31:0] word;
    for (int i = 0; i < 5; i++) begin
        case (i)
            0:       word = 32'h0000_0010;  // UM only
            1:       word = 32'h0000_0012;  // UM with EXL
            2:       word = 32'h0000_0014;  // UM with ERL
            default: word = $random(seed);
        endcase
        writeReg(`CP0_REG_STATUS, word);
        checkReg("rdata_o (Status)", `CP0_REG_STATUS, word & 32'h1040_FF17);
        checkValue("userMode_o", 32'(word[4] & ~word[2] & ~word[1]), 32'(userMode));
    end
    word = $random(seed);
    writeReg(`CP0_REG_EPC, word);
    checkReg("rdata_o (EPC)", `CP0_REG_EPC, word);
    word = $random(seed);
    writeReg(`CP0_REG_BADVADDR, word);
    checkReg("rdata_o (BadVAddr)", `CP0_REG_BADVADDR, word);
    word = $random(seed);
    writeReg(`CP0_REG_CAUSE, word);
    checkReg("rdata_o (Cause)", `CP0_REG_CAUSE, word & 32'h0080_0300);    // IV and IP[1:0]
    writeReg(`CP0_REG_CAUSE, 32'd0);
endtask

task automatic excTest();
    excType_t    kinds [0:8] = '{excIntr, excCpU, excRI, excOv, excTrap,
                                 excSysCall, excBp, excAdEL, excAdES};
    logic [31:0] pc;
    logic [31:0] savedEpc;
    logic        slot;
    for (int i = 0; i < 9; i++) begin
        pc   = $random(seed);
        slot = i[0];
        writeReg(`CP0_REG_STATUS, 32'd0);
        sendExc(kinds[i], pc, 32'd0, 2'd0, slot);
        @(negedge clk);
        checkValue("epc_o", slot ? pc - 32'd4 : pc, epc);
        checkValue("cause_o.bd", 32'(slot), 32'(cause.bd));
        checkValue("cause_o.excCode", 32'(expectedCode(kinds[i])), 32'(cause.excCode));
        checkValue("status_o.exl", 32'd1, 32'(status.exl));
    end
    // EXL still set so the nested fault keeps EPC
    savedEpc = epc;
    sendExc(excBp, $random(seed), 32'd0, 2'd0, 1'b1);
    @(negedge clk);
    checkValue("epc_o after nested exception", savedEpc, epc);
    checkValue("cause_o.excCode", 32'd9, 32'(cause.excCode));
    eret();
    @(negedge clk);
    checkValue("status_o.exl after ERET", 32'd0, 32'(status.exl));
    checkValue("epc_o after ERET", savedEpc, epc);
endtask

task automatic addrCpuTest();
    logic [31:0] addr;
    logic [31:0] pc;
    addr = $random(seed);
    sendExc(excAdEL, 32'h0000_1000, addr, 2'd0, 1'b0);
    checkReg("rdata_o (BadVAddr) after AdEL", `CP0_REG_BADVADDR, addr);
    eret();
    addr = $random(seed);
    sendExc(excAdES, 32'h0000_2000, addr, 2'd0, 1'b0);
    checkReg("rdata_o (BadVAddr) after AdES", `CP0_REG_BADVADDR, addr);
    eret();
    sendExc(excCpU, 32'h0000_3000, 32'd0, 2'd2, 1'b0);
    @(negedge clk);
    checkValue("cause_o.ce", 32'd2, 32'(cause.ce));
    eret();
    // Syscall and EPC write on the same edge
    pc = $random(seed);
    @(posedge clk);
    startWrite(`CP0_REG_EPC, ~pc);
    startExc(excSysCall, pc, 32'd0, 2'd0, 1'b0);
    finishCycle();
    @(negedge clk);
    checkValue("epc_o with concurrent write", pc, epc);
    checkValue("cause_o.excCode", 32'd8, 32'(cause.excCode));
    eret();
endtask

task automatic timerTest();
    logic [31:0] target;
    target        = $random(seed);
    target[31:16] = 16'h0001;   // Far above the running Count
    writeReg(`CP0_REG_COMPARE, target);
    writeReg(`CP0_REG_COUNT, target - 32'd3);
    for (int i = 1; i <= 4; i++) begin
        @(posedge clk);
        @(negedge clk);
        checkValue($sformatf("timerInt_o %0d edges after Count write", i),
                   32'(i == 4), 32'(timerInt));
    end
    repeat (5) begin
        @(negedge clk);
        checkValue("timerInt_o held", 32'd1, 32'(timerInt));
    end
    writeReg(`CP0_REG_COMPARE, 32'd0);
    @(negedge clk);
    checkValue("timerInt_o after Compare write", 32'd0, 32'(timerInt));
    checkReg("rdata_o (Compare)", `CP0_REG_COMPARE, 32'd0);
    writeReg(`CP0_REG_COUNT, 32'hFFFF_FFFC);    // Wraps through zero
    repeat (8) begin
        @(negedge clk);
        checkValue("timerInt_o with Compare zero", 32'd0, 32'(timerInt));
    end
endtask

task automatic intrTest();
    logic [31:0] word;
    logic [5:0]  prev;
    prev = 6'd0;
    for (int i = 0; i < 3; i++) begin
        word = $random(seed);
        if (word[5:0] == prev) begin
            word[5:0] = ~prev;
        end
        @(posedge clk);
        intr <= word[5:0];
        @(negedge clk);
        checkValue("cause_o.ip[7:2] before sampling", 32'(prev), 32'(cause.ip[7:2]));
        @(negedge clk);
        checkValue("cause_o.ip[7:2]", 32'(word[5:0]), 32'(cause.ip[7:2]));
        prev = word[5:0];
    end
    @(posedge clk);
    intr <= '0;
endtask

/* testbench/coprocessor0Tb.sv */
//==================================================
// Coprocessor 0 testbench: clock, reset, DUT,
// watchdog and the directed test sequence
//==================================================
`timescale 1ns/1ps
`include "cp0_settings.svh"

module coprocessor0Tb
    import cp0Pkg::*;
();

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 8;
    // Cycle budget of the six directed tests
    localparam int TEST_CYCLES   = 30 + 60 + 80 + 40 + 40 + 12;
    localparam int MARGIN_CYCLES = 100;

    logic                   clk;
    logic                   rst;
    logic [`CP0_ADDR_W-1:0] regAddr;
    regWrite_t              regWr;
    excReq_t                exc;
    logic [`HW_INT_W-1:0]   intr;
    logic [31:0]            rdata;
    status_t                status;
    cause_t                 cause;
    logic [31:0]            epc;
    logic                   userMode;
    logic                   timerInt;
    int                     errors;
    int                     seed;

    coprocessor0 uut (
        .clk        (clk),
        .rst        (rst),
        .regAddr_i  (regAddr),
        .regWr_i    (regWr),
        .exc_i      (exc),
        .intr_i     (intr),
        .rdata_o    (rdata),
        .status_o   (status),
        .cause_o    (cause),
        .epc_o      (epc),
        .userMode_o (userMode),
        .timerInt_o (timerInt)
    );

    `include "cp0TbTasks.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin : watchdog
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the test sequence did not finish within its cycle budget");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk     = 1'b0;
        rst     = 1'b1;
        regAddr = `CP0_REG_COUNT;   // Count seen right after reset
        regWr   = '0;
        exc     = '0;
        intr    = '0;
        errors  = 0;
        seed    = 37058;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        resetTest();
        writeTest();
        excTest();
        addrCpuTest();
        timerTest();
        intrTest();

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
